// ==== sim.f ====
+incdir+src
+incdir+dv
src/reconPkg.sv
src/fwdTransform.sv
src/quantizer.sv
src/invTransform.sv
src/reconCtrl.sv
src/lumaRecon.sv
dv/tbClock.sv
dv/lumaReconTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the luma reconstruction testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module lumaReconTb -f sim.f -o lumaReconSim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed"
    exit $status
fi

./obj_dir/lumaReconSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with failure status $status"
    exit $status
fi
exit 0

// ==== dv/reconModel.svh ====
// Reference model for luma reconstruction
// Forward transform, quantization, dequantization and reconstruction of one block

`ifndef RECON_MODEL_SVH
`define RECON_MODEL_SVH

// Residual, row butterflies then column butterflies
function automatic coeffBlockT residualTransform(input pixelBlockT s, input pixelBlockT p);
    int         d [numCoeff];
    int         t [numCoeff];
    int         e0, e1, o0, o1;
    coeffBlockT res;
    for (int k = 0; k < numCoeff; k++) begin
        d[k] = int'(s[k]) - int'(p[k]);
    end
    for (int i = 0; i < numCoeff; i += `BLOCK_DIM) begin
        e0 = d[i] + d[i + 3];
        e1 = d[i + 1] + d[i + 2];
        o0 = d[i + 1] - d[i + 2];
        o1 = d[i] - d[i + 3];
        t[i]     = (e0 + e1) * 8;
        t[i + 2] = (e0 - e1) * 8;
        t[i + 1] = (o0 * 2217 + o1 * 5352 + 1812) >>> 9;
        t[i + 3] = (o1 * 2217 - o0 * 5352 + 937) >>> 9;
    end
    for (int j = 0; j < `BLOCK_DIM; j++) begin
        e0 = t[j] + t[j + 12];
        e1 = t[j + 4] + t[j + 8];
        o0 = t[j + 4] - t[j + 8];
        o1 = t[j] - t[j + 12];
        res[j]      = coeffT'((e0 + e1 + 7) >>> 4);
        res[j + 8]  = coeffT'((e0 - e1 + 7) >>> 4);
        res[j + 4]  = coeffT'(((o0 * 2217 + o1 * 5352 + 12000) >>> 16) + ((o1 != 0) ? 1 : 0));
        res[j + 12] = coeffT'((o1 * 2217 - o0 * 5352 + 51000) >>> 16);
    end
    return res;
endfunction

// DC set for index 0 and AC set for the rest
function automatic levelBlockT quantizeLevels(input coeffBlockT c, input quantT dcIq,
                                              input quantT dcBias, input quantT acIq,
                                              input quantT acBias);
    longint     mag;
    longint     lvl;
    levelBlockT res;
    for (int k = 0; k < numCoeff; k++) begin
        mag = longint'(c[k]);
        if (mag < 0) begin
            mag = -mag;
        end
        if (k == 0) begin
            lvl = (mag * longint'(dcIq) + longint'(dcBias)) >> `QUANT_SHIFT;
        end else begin
            lvl = (mag * longint'(acIq) + longint'(acBias)) >> `QUANT_SHIFT;
        end
        if (lvl > `MAX_LEVEL) begin
            lvl = `MAX_LEVEL;
        end
        res[k] = levelT'((c[k] < 0) ? -lvl : lvl);
    end
    return res;
endfunction

function automatic logic [numCoeff-1:0] nonzeroFlags(input levelBlockT l);
    logic [numCoeff-1:0] res;
    for (int k = 0; k < numCoeff; k++) begin
        res[k] = (l[k] != 0);
    end
    return res;
endfunction

function automatic coeffBlockT dequantizeLevels(input levelBlockT l, input quantT dcQ,
                                                input quantT acQ);
    coeffBlockT res;
    for (int k = 0; k < numCoeff; k++) begin
        res[k] = coeffT'(int'(l[k]) * int'((k == 0) ? dcQ : acQ));
    end
    return res;
endfunction

// sqrt2 * cos(pi/8) as 1 + 20091/65536
function automatic longint cosTerm(input longint x);
    return x + ((x * 20091) >>> 16);
endfunction

// sqrt2 * sin(pi/8)
function automatic longint sinTerm(input longint x);
    return (x * 35468) >>> 16;
endfunction

function automatic pixelT clipPixel(input longint v);
    if (v < 0) begin
        return 8'd0;
    end
    if (v > 255) begin
        return 8'd255;
    end
    return pixelT'(v);
endfunction

// Vertical pass, horizontal pass with rounding, prediction add and clip
function automatic pixelBlockT reconstructBlock(input coeffBlockT dq, input pixelBlockT p);
    longint     m [numCoeff];
    longint     a, b, c, d;
    pixelBlockT res;
    for (int j = 0; j < `BLOCK_DIM; j++) begin
        a = longint'(dq[j]) + longint'(dq[j + 8]);
        b = longint'(dq[j]) - longint'(dq[j + 8]);
        c = sinTerm(longint'(dq[j + 4])) - cosTerm(longint'(dq[j + 12]));
        d = cosTerm(longint'(dq[j + 4])) + sinTerm(longint'(dq[j + 12]));
        m[j]      = a + d;
        m[j + 4]  = b + c;
        m[j + 8]  = b - c;
        m[j + 12] = a - d;
    end
    for (int i = 0; i < numCoeff; i += `BLOCK_DIM) begin
        a = m[i] + m[i + 2];
        b = m[i] - m[i + 2];
        c = sinTerm(m[i + 1]) - cosTerm(m[i + 3]);
        d = cosTerm(m[i + 1]) + sinTerm(m[i + 3]);
        res[i]     = clipPixel(longint'(p[i])     + ((a + d + 4) >>> 3));
        res[i + 1] = clipPixel(longint'(p[i + 1]) + ((b + c + 4) >>> 3));
        res[i + 2] = clipPixel(longint'(p[i + 2]) + ((b - c + 4) >>> 3));
        res[i + 3] = clipPixel(longint'(p[i + 3]) + ((a - d + 4) >>> 3));
    end
    return res;
endfunction

`endif

// ==== dv/lumaReconTb.sv ====
// Luma reconstruction testbench
// Table driven req/ack stimulus with outputs checked against the reference model

`include "recon_cfg.svh"

module lumaReconTb;
    timeunit 1ns;
    timeprecision 100ps;

    import reconPkg::*;

    `include "reconModel.svh"

    localparam int periodNs   = 100;
    localparam int driveDelay = 10;
    localparam int ackLimit   = 4 * `PIPE_LATENCY;

    // Quantizer sets picked by index from the table
    localparam quantT stepTab  [5] = '{1, 4, 8, 40, 60};
    localparam quantT recipTab [5] = '{65535, 32768, 16384, 3277, 2185};
    localparam quantT biasTab  [5] = '{0, 43690, 43690, 43690, 43690};

    typedef struct packed {
        int srcBase;
        int srcStepX;
        int srcStepY;
        int predBase;
        int predStepX;
        int predStepY;
        int randomPix;
        int dcSet;
        int acSet;
        int holdCycles;
        int expMask;
        int predOut;
        int swapOfPrev;
        int maskFromModel;
    } stimRowT;

    logic                clk;
    logic                rst_n;
    logic                req;
    pixelBlockT          src;
    pixelBlockT          pred;
    quantT               dcQ, dcIq, dcBias, acQ, acIq, acBias;
    logic                ack;
    levelBlockT          levels;
    logic [numCoeff-1:0] nzMask;
    pixelBlockT          recon;

    int                  seed;
    logic                tableReady;
    stimRowT             stimTable [$];

    tbClock #(.periodNs(periodNs), .resetCycles(4)) uClock (.clk(clk), .rst_n(rst_n));

    lumaRecon DUT (
        .clk(clk), .rst_n(rst_n), .req(req), .src(src), .pred(pred),
        .dcQ(dcQ), .dcIq(dcIq), .dcBias(dcBias), .acQ(acQ), .acIq(acIq), .acBias(acBias),
        .ack(ack), .levels(levels), .nzMask(nzMask), .recon(recon)
    );

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkValue(input string name, input longint expected, input longint actual);
        assert (expected == actual) else begin
            abortRun($sformatf("Error at %0d ns: %s expected %0d, actual %0d",
                               $time, name, expected, actual));
        end
    endtask

    function automatic pixelT patternPixel(input int base, input int stepX, input int stepY,
                                           input int k);
        return clipPixel(base + stepX * (k % `BLOCK_DIM) + stepY * (k / `BLOCK_DIM));
    endfunction

    task automatic buildBlocks(input stimRowT row, output pixelBlockT s, output pixelBlockT p);
        for (int k = 0; k < numCoeff; k++) begin
            if (row.randomPix != 0) begin
                s[k] = pixelT'($random(seed));
                p[k] = pixelT'($random(seed));
            end else begin
                s[k] = patternPixel(row.srcBase, row.srcStepX, row.srcStepY, k);
                p[k] = patternPixel(row.predBase, row.predStepX, row.predStepY, k);
            end
        end
    endtask

    task automatic fillTable();
        // srcBase sx sy, predBase sx sy, random, dcSet acSet, hold, mask, predOut swap model
        stimTable.push_back(stimRowT'{30, 9, 13,  50, 0, 0,  0, 2, 3, 4, 0, 0, 0, 1});
        stimTable.push_back(stimRowT'{60, 3, 7,   60, 3, 7,  0, 2, 3, 0, 0, 1, 0, 0});
        stimTable.push_back(stimRowT'{60, 5, 9,   40, 5, 9,  0, 2, 3, 0, 1, 0, 0, 0});
        stimTable.push_back(stimRowT'{20, 40, 25, 100, 0, 0, 0, 1, 4, 0, 0, 0, 0, 1});
        stimTable.push_back(stimRowT'{20, 40, 25, 100, 0, 0, 0, 4, 1, 0, 0, 0, 1, 1});
        stimTable.push_back(stimRowT'{255, 0, 0,  0, 0, 0,   0, 0, 0, 0, 0, 0, 0, 1});
        stimTable.push_back(stimRowT'{0, 0, 0,    0, 0, 0,   1, 2, 3, 0, 0, 0, 0, 1});
        stimTable.push_back(stimRowT'{0, 0, 0,    0, 0, 0,   1, 1, 2, 0, 0, 0, 0, 1});
        stimTable.push_back(stimRowT'{0, 0, 0,    0, 0, 0,   1, 0, 4, 0, 0, 0, 0, 1});
        stimTable.push_back(stimRowT'{0, 0, 0,    0, 0, 0,   1, 3, 1, 0, 0, 0, 0, 1});
        stimTable.push_back(stimRowT'{0, 0, 0,    0, 0, 0,   1, 2, 2, 0, 0, 0, 0, 1});
        stimTable.push_back(stimRowT'{0, 0, 0,    0, 0, 0,   1, 1, 3, 0, 0, 0, 0, 1});
    endtask

    // ----------------------------------------------------------
    // One block through the four-phase handshake
    // ----------------------------------------------------------
    task automatic runRow(input stimRowT row);
        pixelBlockT          s;
        pixelBlockT          p;
        coeffBlockT          expCoeff;
        levelBlockT          expLevels;
        levelBlockT          swapLevels;
        logic [numCoeff-1:0] expMask;
        pixelBlockT          expRecon;
        int                  edgeIdx;
        buildBlocks(row, s, p);
        expCoeff   = residualTransform(s, p);
        expLevels  = quantizeLevels(expCoeff, recipTab[row.dcSet], biasTab[row.dcSet],
                                    recipTab[row.acSet], biasTab[row.acSet]);
        // Same block with the DC and AC sets exchanged
        swapLevels = quantizeLevels(expCoeff, recipTab[row.acSet], biasTab[row.acSet],
                                    recipTab[row.dcSet], biasTab[row.dcSet]);
        expMask    = (row.maskFromModel != 0) ? nonzeroFlags(expLevels) : row.expMask[15:0];
        expRecon   = reconstructBlock(dequantizeLevels(expLevels, stepTab[row.dcSet],
                                                       stepTab[row.acSet]), p);
        src    = s;
        pred   = p;
        dcQ    = stepTab[row.dcSet];
        dcIq   = recipTab[row.dcSet];
        dcBias = biasTab[row.dcSet];
        acQ    = stepTab[row.acSet];
        acIq   = recipTab[row.acSet];
        acBias = biasTab[row.acSet];
        req    = 1'b1;
        // Edge 0 is the first one that sees req high
        edgeIdx = -1;
        do begin
            @(posedge clk);
            edgeIdx++;
            #driveDelay;
        end while (!ack && edgeIdx < ackLimit);
        assert (ack) else abortRun("The DUT never raised ack after req was raised");
        checkValue("ack rise edge", 1 + `PIPE_LATENCY, edgeIdx);
        for (int k = 0; k < numCoeff; k++) begin
            checkValue($sformatf("levels[%0d]", k), expLevels[k], levels[k]);
            checkValue($sformatf("recon[%0d]", k), expRecon[k], recon[k]);
            if (row.predOut != 0) begin
                checkValue($sformatf("levels[%0d]", k), 0, levels[k]);
                checkValue($sformatf("recon[%0d]", k), p[k], recon[k]);
            end
        end
        checkValue("nzMask", expMask, nzMask);
        if (row.swapOfPrev != 0) begin
            assert (levels != swapLevels) else begin
                abortRun("The levels equal those of the exchanged DC and AC quantizer sets");
            end
        end
        // Outputs frozen while the master holds req
        repeat (row.holdCycles) begin
            @(posedge clk);
            #driveDelay;
            checkValue("ack", 1, ack);
            checkValue("nzMask", expMask, nzMask);
            for (int k = 0; k < numCoeff; k++) begin
                checkValue($sformatf("levels[%0d]", k), expLevels[k], levels[k]);
                checkValue($sformatf("recon[%0d]", k), expRecon[k], recon[k]);
            end
        end
        req = 1'b0;
        @(posedge clk);
        #driveDelay;
        checkValue("ack", 0, ack);
    endtask

    initial begin
        req        = 1'b0;
        src        = '0;
        pred       = '0;
        dcQ        = '0;
        dcIq       = '0;
        dcBias     = '0;
        acQ        = '0;
        acIq       = '0;
        acBias     = '0;
        seed       = 32'h64f8_efe1;
        tableReady = 1'b0;
        fillTable();
        tableReady = 1'b1;
        wait (rst_n === 1'b1);
        @(posedge clk);
        #driveDelay;
        checkValue("ack", 0, ack);
        foreach (stimTable[i]) begin
            runRow(stimTable[i]);
        end
        $display("test passed");
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (tableReady === 1'b1);
        #((stimTable.size() * 12 + 20) * periodNs);
        abortRun("Timeout: the watchdog expired before all table rows completed");
    end

endmodule

// ==== dv/tbClock.sv ====
// Testbench clock and reset
// Free running clock and an active low reset held for a few cycles

module tbClock #(
    parameter int periodNs    = 100,
    parameter int resetCycles = 4
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Release shortly after an edge, away from sampling
    initial begin
        rst_n = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #(periodNs / 10) rst_n = 1'b1;
    end

endmodule

// ==== src/lumaRecon.sv ====
// Luma 4x4 reconstruction top
// Controller plus forward transform, quantizer and inverse transform stages

module lumaRecon (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          req,
    input  reconPkg::pixelBlockT          src,
    input  reconPkg::pixelBlockT          pred,
    input  reconPkg::quantT               dcQ,
    input  reconPkg::quantT               dcIq,
    input  reconPkg::quantT               dcBias,
    input  reconPkg::quantT               acQ,
    input  reconPkg::quantT               acIq,
    input  reconPkg::quantT               acBias,
    output logic                          ack,
    output reconPkg::levelBlockT          levels,
    output logic [reconPkg::numCoeff-1:0] nzMask,
    output reconPkg::pixelBlockT          recon
);
    import reconPkg::*;

    logic       start;
    pixelBlockT srcReg;
    pixelBlockT predReg;
    quantT      dcQReg;
    quantT      dcIqReg;
    quantT      dcBiasReg;
    quantT      acQReg;
    quantT      acIqReg;
    quantT      acBiasReg;
    coeffBlockT coeff;
    logic       coeffValid;
    coeffBlockT dequant;
    logic       dqValid;
    logic       reconValid;

    reconCtrl uCtrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .src        (src),
        .pred       (pred),
        .dcQ        (dcQ),
        .dcIq       (dcIq),
        .dcBias     (dcBias),
        .acQ        (acQ),
        .acIq       (acIq),
        .acBias     (acBias),
        .reconValid (reconValid),
        .ack        (ack),
        .start      (start),
        .srcReg     (srcReg),
        .predReg    (predReg),
        .dcQReg     (dcQReg),
        .dcIqReg    (dcIqReg),
        .dcBiasReg  (dcBiasReg),
        .acQReg     (acQReg),
        .acIqReg    (acIqReg),
        .acBiasReg  (acBiasReg)
    );

    fwdTransform uFwd (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .srcReg     (srcReg),
        .predReg    (predReg),
        .coeff      (coeff),
        .coeffValid (coeffValid)
    );

    quantizer uQuant (
        .clk        (clk),
        .rst_n      (rst_n),
        .coeff      (coeff),
        .coeffValid (coeffValid),
        .dcQReg     (dcQReg),
        .dcIqReg    (dcIqReg),
        .dcBiasReg  (dcBiasReg),
        .acQReg     (acQReg),
        .acIqReg    (acIqReg),
        .acBiasReg  (acBiasReg),
        .levels     (levels),
        .nzMask     (nzMask),
        .dequant    (dequant),
        .dqValid    (dqValid)
    );

    invTransform uInv (
        .clk        (clk),
        .rst_n      (rst_n),
        .dequant    (dequant),
        .dqValid    (dqValid),
        .predReg    (predReg),
        .recon      (recon),
        .reconValid (reconValid)
    );

endmodule

// ==== src/reconCtrl.sv ====
// Reconstruction controller
// Four-phase req/ack FSM, input capture and datapath start

`include "recon_cfg.svh"

module reconCtrl (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 req,
    input  reconPkg::pixelBlockT src,
    input  reconPkg::pixelBlockT pred,
    input  reconPkg::quantT      dcQ,
    input  reconPkg::quantT      dcIq,
    input  reconPkg::quantT      dcBias,
    input  reconPkg::quantT      acQ,
    input  reconPkg::quantT      acIq,
    input  reconPkg::quantT      acBias,
    input  logic                 reconValid,
    output logic                 ack,
    output logic                 start,
    output reconPkg::pixelBlockT srcReg,
    output reconPkg::pixelBlockT predReg,
    output reconPkg::quantT      dcQReg,
    output reconPkg::quantT      dcIqReg,
    output reconPkg::quantT      dcBiasReg,
    output reconPkg::quantT      acQReg,
    output reconPkg::quantT      acIqReg,
    output reconPkg::quantT      acBiasReg
);
    import reconPkg::*;

    ctrlStateT state;
    ctrlStateT stateNext;
    logic      accept;

    assign accept = (state == Idle) && req;
    assign ack    = (state == Ack);

    always_comb begin
        stateNext = state;
        case (state)
            Idle: if (req) stateNext = Busy;
            // Block in flight until the token returns
            Busy: if (reconValid) stateNext = Ack;
            Ack:  if (!req) stateNext = Idle;
            default: stateNext = Idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= Idle;
            start <= 1'b0;
        end else begin
            state <= stateNext;
            start <= accept;
        end
    end

    // Inputs held stable for the whole block
    always_ff @(posedge clk) begin
        if (accept) begin
            srcReg    <= src;
            predReg   <= pred;
            dcQReg    <= dcQ;
            dcIqReg   <= dcIq;
            dcBiasReg <= dcBias;
            acQReg    <= acQ;
            acIqReg   <= acIq;
            acBiasReg <= acBias;
        end
    end

    // ----------------------------------------------------------
    // Handshake and pipeline checks
    // ----------------------------------------------------------

    // ack only while the master keeps its request up
    assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> $past(req));

    // Token never returns unless a block is in flight
    assert property (@(posedge clk) disable iff (!rst_n)
        reconValid |-> (state == Busy));

    // Token comes back a fixed number of cycles after start
    assert property (@(posedge clk) disable iff (!rst_n)
        start |-> ##(`PIPE_LATENCY) reconValid);

endmodule

// ==== src/invTransform.sv ====
// Inverse transform
// VP8 style 4x4 inverse transform, prediction add and 8-bit clip, two registered passes

`include "recon_cfg.svh"

module invTransform (
    input  logic                 clk,
    input  logic                 rst_n,
    input  reconPkg::coeffBlockT dequant,
    input  logic                 dqValid,
    input  reconPkg::pixelBlockT predReg,
    output reconPkg::pixelBlockT recon,
    output logic                 reconValid
);
    import reconPkg::*;

    // Room for the vertical butterfly growth
    typedef logic signed [`COEFF_W+3:0] midT;

    midT        midNext [numCoeff];
    midT        midReg  [numCoeff];
    logic       midValid;
    pixelBlockT reconNext;

    // x * (1 + 20091 / 65536)
    function automatic longint mul1(input longint a);
        return ((a * 20091) >>> 16) + a;
    endfunction

    // x * 35468 / 65536
    function automatic longint mul2(input longint a);
        return (a * 35468) >>> 16;
    endfunction

    function automatic pixelT clip8(input longint v);
        if (v < 0) begin
            return '0;
        end
        if (v > (1 << `PIXEL_W) - 1) begin
            return '1;
        end
        return pixelT'(v);
    endfunction

    // ----------------------------------------------------------
    // Pass 1: vertical butterflies
    // ----------------------------------------------------------
    always_comb begin
        longint a, b, c, d;
        for (int col = 0; col < `BLOCK_DIM; col++) begin
            a = longint'(dequant[col]) + longint'(dequant[2 * `BLOCK_DIM + col]);
            b = longint'(dequant[col]) - longint'(dequant[2 * `BLOCK_DIM + col]);
            c = mul2(dequant[`BLOCK_DIM + col]) - mul1(dequant[3 * `BLOCK_DIM + col]);
            d = mul1(dequant[`BLOCK_DIM + col]) + mul2(dequant[3 * `BLOCK_DIM + col]);
            midNext[col]                  = midT'(a + d);
            midNext[`BLOCK_DIM + col]     = midT'(b + c);
            midNext[2 * `BLOCK_DIM + col] = midT'(b - c);
            midNext[3 * `BLOCK_DIM + col] = midT'(a - d);
        end
    end

    // ----------------------------------------------------------
    // Pass 2: horizontal butterflies, prediction add, clip
    // ----------------------------------------------------------
    always_comb begin
        int     base;
        longint dc, a, b, c, d;
        longint v [`BLOCK_DIM];
        for (int row = 0; row < `BLOCK_DIM; row++) begin
            base = row * `BLOCK_DIM;
            dc   = longint'(midReg[base]) + 4;
            a    = dc + longint'(midReg[base + 2]);
            b    = dc - longint'(midReg[base + 2]);
            c    = mul2(midReg[base + 1]) - mul1(midReg[base + 3]);
            d    = mul1(midReg[base + 1]) + mul2(midReg[base + 3]);
            v[0] = a + d;
            v[1] = b + c;
            v[2] = b - c;
            v[3] = a - d;
            for (int col = 0; col < `BLOCK_DIM; col++) begin
                reconNext[base + col] =
                    clip8(longint'(predReg[base + col]) + (v[col] >>> 3));
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            midValid   <= 1'b0;
            reconValid <= 1'b0;
        end else begin
            midValid   <= dqValid;
            reconValid <= midValid;
        end
    end

    always_ff @(posedge clk) begin
        if (dqValid) begin
            midReg <= midNext;
        end
        if (midValid) begin
            recon <= reconNext;
        end
    end

endmodule

// ==== src/quantizer.sv ====
// Quantizer
// Per-coefficient quantization with DC and AC sets, dequantization and nonzero flags

`include "recon_cfg.svh"

module quantizer (
    input  logic                          clk,
    input  logic                          rst_n,
    input  reconPkg::coeffBlockT          coeff,
    input  logic                          coeffValid,
    input  reconPkg::quantT               dcQReg,
    input  reconPkg::quantT               dcIqReg,
    input  reconPkg::quantT               dcBiasReg,
    input  reconPkg::quantT               acQReg,
    input  reconPkg::quantT               acIqReg,
    input  reconPkg::quantT               acBiasReg,
    output reconPkg::levelBlockT          levels,
    output logic [reconPkg::numCoeff-1:0] nzMask,
    output reconPkg::coeffBlockT          dequant,
    output logic                          dqValid
);
    import reconPkg::*;

    levelBlockT          levelNext;
    coeffBlockT          dequantNext;
    logic [numCoeff-1:0] nzNext;

    always_comb begin
        quantT  q;
        quantT  iq;
        quantT  bias;
        int     absC;
        longint mag;
        int     lvl;
        for (int k = 0; k < numCoeff; k++) begin
            // Index 0 is DC
            q    = (k == 0) ? dcQReg    : acQReg;
            iq   = (k == 0) ? dcIqReg   : acIqReg;
            bias = (k == 0) ? dcBiasReg : acBiasReg;
            absC = (coeff[k] < 0) ? -int'(coeff[k]) : int'(coeff[k]);
            mag  = (longint'(absC) * longint'(iq) + longint'(bias)) >>> `QUANT_SHIFT;
            lvl  = (mag > `MAX_LEVEL) ? `MAX_LEVEL : int'(mag);
            if (coeff[k] < 0) begin
                lvl = -lvl;
            end
            levelNext[k] = levelT'(lvl);
            nzNext[k]    = (lvl != 0);
            // Product is truncated to the coefficient width
            dequantNext[k] = coeffT'(lvl * int'(q));
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dqValid <= 1'b0;
        end else begin
            dqValid <= coeffValid;
        end
    end

    always_ff @(posedge clk) begin
        if (coeffValid) begin
            levels  <= levelNext;
            nzMask  <= nzNext;
            dequant <= dequantNext;
        end
    end

    // Every level published with dqValid sits inside the clamp
    for (genvar k = 0; k < numCoeff; k++) begin : gLevelCheck
        assert property (@(posedge clk) disable iff (!rst_n)
            dqValid |-> (levels[k] <= `MAX_LEVEL) && (levels[k] >= -`MAX_LEVEL));
    end

endmodule

// ==== src/fwdTransform.sv ====
// Forward transform
// Residual and VP8 style 4x4 integer transform in two registered passes

`include "recon_cfg.svh"

module fwdTransform (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  reconPkg::pixelBlockT srcReg,
    input  reconPkg::pixelBlockT predReg,
    output reconPkg::coeffBlockT coeff,
    output logic                 coeffValid
);
    import reconPkg::*;

    coeffBlockT rowNext;
    coeffBlockT rowReg;
    coeffBlockT colNext;
    logic       rowValid;

    // ----------------------------------------------------------
    // Pass 1: residual and row butterflies
    // ----------------------------------------------------------
    always_comb begin
        int base;
        int d0, d1, d2, d3;
        int a0, a1, a2, a3;
        for (int r = 0; r < `BLOCK_DIM; r++) begin
            base = r * `BLOCK_DIM;
            d0 = int'(srcReg[base])     - int'(predReg[base]);
            d1 = int'(srcReg[base + 1]) - int'(predReg[base + 1]);
            d2 = int'(srcReg[base + 2]) - int'(predReg[base + 2]);
            d3 = int'(srcReg[base + 3]) - int'(predReg[base + 3]);
            a0 = d0 + d3;
            a1 = d1 + d2;
            a2 = d1 - d2;
            a3 = d0 - d3;
            rowNext[base]     = coeffT'((a0 + a1) * 8);
            rowNext[base + 1] = coeffT'((a2 * 2217 + a3 * 5352 + 1812) >>> 9);
            rowNext[base + 2] = coeffT'((a0 - a1) * 8);
            rowNext[base + 3] = coeffT'((a3 * 2217 - a2 * 5352 + 937) >>> 9);
        end
    end

    // ----------------------------------------------------------
    // Pass 2: column butterflies
    // ----------------------------------------------------------
    always_comb begin
        int a0, a1, a2, a3;
        int odd;
        for (int c = 0; c < `BLOCK_DIM; c++) begin
            a0 = int'(rowReg[c])                  + int'(rowReg[3 * `BLOCK_DIM + c]);
            a1 = int'(rowReg[`BLOCK_DIM + c])     + int'(rowReg[2 * `BLOCK_DIM + c]);
            a2 = int'(rowReg[`BLOCK_DIM + c])     - int'(rowReg[2 * `BLOCK_DIM + c]);
            a3 = int'(rowReg[c])                  - int'(rowReg[3 * `BLOCK_DIM + c]);
            odd = (a3 != 0) ? 1 : 0;
            colNext[c] = coeffT'((a0 + a1 + 7) >>> 4);
            colNext[`BLOCK_DIM + c] =
                coeffT'(((a2 * 2217 + a3 * 5352 + 12000) >>> 16) + odd);
            colNext[2 * `BLOCK_DIM + c] = coeffT'((a0 - a1 + 7) >>> 4);
            colNext[3 * `BLOCK_DIM + c] =
                coeffT'((a3 * 2217 - a2 * 5352 + 51000) >>> 16);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rowValid   <= 1'b0;
            coeffValid <= 1'b0;
        end else begin
            rowValid   <= start;
            coeffValid <= rowValid;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            rowReg <= rowNext;
        end
        if (rowValid) begin
            coeff <= colNext;
        end
    end

endmodule

// ==== src/reconPkg.sv ====
// Luma reconstruction types
// Pixel, coefficient and level blocks plus the controller states

`include "recon_cfg.svh"

package reconPkg;

    localparam int numCoeff = `BLOCK_DIM * `BLOCK_DIM;

    typedef logic        [`PIXEL_W-1:0] pixelT;
    typedef logic signed [`COEFF_W-1:0] coeffT;
    typedef logic signed [`LEVEL_W-1:0] levelT;

    // Raster order, index 0 is top left (DC for coefficients)
    typedef pixelT [numCoeff-1:0] pixelBlockT;
    typedef coeffT [numCoeff-1:0] coeffBlockT;
    typedef levelT [numCoeff-1:0] levelBlockT;

    // Quantizer step, reciprocal or rounding bias
    typedef logic [15:0] quantT;

    typedef enum logic [1:0] {
        Idle,
        Busy,
        Ack
    } ctrlStateT;

endpackage

// ==== src/recon_cfg.svh ====
// Luma reconstruction configuration
// Block geometry, datapath widths, quantizer constants and pipeline depth

`ifndef RECON_CFG_SVH
`define RECON_CFG_SVH

// Block geometry
`define BLOCK_DIM    4

// Datapath widths
`define PIXEL_W      8
`define COEFF_W      16
`define LEVEL_W      12

// Quantizer fixed point and level clamp
`define QUANT_SHIFT  17
`define MAX_LEVEL    2047

// Register stages from start to reconValid
`define PIPE_LATENCY 5

`endif
